/* board_regs.sv */
module board_regs
    import dqla_pkg::*;
(
    input  logic        sysclk,
    input  logic        arst_n,
    input  logic [15:0] reg_waddr,
    input  logic [31:0] reg_wdata,
    input  logic        reg_wen,
    input  logic [15:0] reg_raddr,
    input  logic [3:0]  board_id,
    input  logic        wdog_timeout,
    output logic        pwr_en,          // Board power to amps
    output logic        relay_on,        // Safety relay
    output logic [7:0]  dout,
    output logic        pwr_enable_cmd,  // Host power-on attempt
    output logic [31:0] board_rdata
);

    logic        wr_chan0;
    board_reg_e  wr_off;
    board_reg_e  rd_off;
    logic        status_wr;
    logic        dout_wr;
    logic [31:0] status_word;

    // --------------------------------------------------
    // Write decode, channel 0 only
    // --------------------------------------------------
    assign wr_chan0  = reg_wen && (addr_space_e'(reg_waddr[15:12]) == ADDR_MAIN)
                    && (reg_waddr[7:4] == 4'd0);
    assign wr_off    = board_reg_e'(reg_waddr[3:0]);
    assign status_wr = wr_chan0 && (wr_off == REG_STATUS);
    assign dout_wr   = wr_chan0 && (wr_off == REG_DOUT);

    // Both mask and value set
    assign pwr_enable_cmd = status_wr && reg_wdata[PWR_MASK_BIT] && reg_wdata[PWR_VAL_BIT];

    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            pwr_en   <= 1'b0;
            relay_on <= 1'b0;
            dout     <= '0;
        end else begin
            if (wdog_timeout) begin
                pwr_en <= 1'b0;  // Beats a same-cycle write
            end else if (status_wr && reg_wdata[PWR_MASK_BIT]) begin
                pwr_en <= reg_wdata[PWR_VAL_BIT];
            end
            if (status_wr && reg_wdata[RELAY_MASK_BIT]) begin
                relay_on <= reg_wdata[RELAY_VAL_BIT];
            end
            if (dout_wr) begin
                dout <= reg_wdata[7:0];
            end
        end
    end

    // --------------------------------------------------
    // Read side, offset only
    // --------------------------------------------------
    always_comb begin
        status_word                                    = '0;
        status_word[BOARD_ID_LSB +: 4]                 = board_id;
        status_word[WDOG_BIT]                          = wdog_timeout;
        status_word[PWR_STAT_BIT]                      = pwr_en;
        status_word[RELAY_STAT_BIT]                    = relay_on;
    end

    assign rd_off = board_reg_e'(reg_raddr[3:0]);

    always_comb begin
        case (rd_off)
            REG_STATUS: board_rdata = status_word;
            REG_DOUT:   board_rdata = {24'd0, dout};
            default:    board_rdata = '0;  // Unused offsets
        endcase
    end

endmodule

/* dac_spi_chain.sv */
module dac_spi_chain
    import dqla_pkg::*;
#(
    parameter int DACS_PER_CHAIN = 4
) (
    input  logic                 sysclk,
    input  logic                 arst_n,
    input  logic [15:0]          reg_waddr,
    input  logic                 reg_wen,
    input  logic                 blk_wen,   // Block write in progress
    input  logic [CUR_CMD_W-1:0] cur_cmd [1:2*DACS_PER_CHAIN],
    output logic                 sclk,      // Shared by both chains
    output logic [1:0]           mosi,
    output logic [1:0]           csn
);

    localparam int NUM_DACS = 2 * DACS_PER_CHAIN;
    localparam int FRAME_W  = (DACS_PER_CHAIN > 1) ? $clog2(DACS_PER_CHAIN) : 1;
    localparam int BIT_W    = $clog2(DAC_FRAME_BITS);

    dac_state_e                state;
    logic                      dac_wr;
    logic                      cur_cmd_req;  // Pending update
    logic                      start;
    logic                      last_bit;
    logic                      last_frame;
    logic                      load_next;
    logic [BIT_W-1:0]          bit_cnt;
    logic [FRAME_W-1:0]        frame_cnt;
    logic                      gap_cnt;
    logic                      csn_q;
    logic [DAC_FRAME_BITS-1:0] shift_q [2];
    logic [CUR_CMD_W-1:0]      cmd_hold [1:NUM_DACS];

    // Command nibble, four zero bits, data MSB first
    function automatic logic [DAC_FRAME_BITS-1:0] build_frame(
        input logic [CUR_CMD_W-1:0] val
    );
        return {DAC_CMD_WRITE_UPDATE, 4'b0000, val};
    endfunction

    // DAC_CTRL write to any motor channel
    assign dac_wr = reg_wen && (addr_space_e'(reg_waddr[15:12]) == ADDR_MAIN)
                 && (reg_waddr[7:4] != 4'd0) && (reg_waddr[7:4] <= 4'(NUM_DACS))
                 && (chan_reg_e'(reg_waddr[3:0]) == OFF_DAC_CTRL);

    assign start      = cur_cmd_req && (state == DAC_IDLE);
    assign last_bit   = (bit_cnt == BIT_W'(DAC_FRAME_BITS - 1));
    assign last_frame = (frame_cnt == FRAME_W'(DACS_PER_CHAIN - 1));
    assign load_next  = (state == DAC_GAP) && gap_cnt && !last_frame;

    // --------------------------------------------------
    // Update request, merges while busy
    // --------------------------------------------------
    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            cur_cmd_req <= 1'b0;
        end else if (dac_wr) begin
            cur_cmd_req <= blk_wen;  // Plain write cancels
        end else if (start) begin
            cur_cmd_req <= 1'b0;
        end
    end

    // --------------------------------------------------
    // Frame sequencer
    // --------------------------------------------------
    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= DAC_IDLE;
            sclk      <= 1'b0;
            csn_q     <= 1'b1;
            bit_cnt   <= '0;
            frame_cnt <= '0;
            gap_cnt   <= 1'b0;
        end else begin
            case (state)
                DAC_IDLE: begin
                    if (start) begin
                        state     <= DAC_SHIFT;
                        csn_q     <= 1'b0;
                        sclk      <= 1'b0;
                        bit_cnt   <= '0;
                        frame_cnt <= '0;
                    end
                end
                DAC_SHIFT: begin
                    sclk <= !sclk;  // Period of 2 sysclk
                    if (sclk) begin
                        if (last_bit) begin
                            state   <= DAC_GAP;
                            csn_q   <= 1'b1;
                            gap_cnt <= 1'b0;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                end
                DAC_GAP: begin
                    gap_cnt <= 1'b1;
                    if (gap_cnt) begin
                        if (last_frame) begin
                            state <= DAC_IDLE;
                        end else begin
                            state     <= DAC_SHIFT;
                            csn_q     <= 1'b0;
                            bit_cnt   <= '0;
                            frame_cnt <= frame_cnt + 1'b1;
                        end
                    end
                end
                default: state <= DAC_IDLE;
            endcase
        end
    end

    // Shift registers, moved on falling sclk
    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            shift_q <= '{default: '0};
        end else begin
            for (int c = 0; c < 2; c++) begin
                if (start) begin
                    shift_q[c] <= build_frame(cur_cmd[c * DACS_PER_CHAIN + 1]);
                end else if (load_next) begin
                    shift_q[c] <= build_frame(cmd_hold[c * DACS_PER_CHAIN + frame_cnt + 2]);
                end else if ((state == DAC_SHIFT) && sclk) begin
                    shift_q[c] <= {shift_q[c][DAC_FRAME_BITS-2:0], 1'b0};
                end
            end
        end
    end

    // Currents frozen for the whole transfer
    always_ff @(posedge sysclk) begin
        if (start) begin
            cmd_hold <= cur_cmd;
        end
    end

    assign mosi[0] = shift_q[0][DAC_FRAME_BITS-1];
    assign mosi[1] = shift_q[1][DAC_FRAME_BITS-1];
    assign csn     = {2{csn_q}};

endmodule

/* dqla_pkg.sv */
package dqla_pkg;

    // --------------------------------------------------
    // Register bus address fields
    // --------------------------------------------------

    // Address space, reg_addr[15:12]
    typedef enum logic [3:0] {
        ADDR_MAIN     = 4'h0,  // Board and motor channels
        ADDR_HUB      = 4'h1,
        ADDR_PROM     = 4'h2,
        ADDR_PROM_QLA = 4'h3,
        ADDR_ETH      = 4'h4
    } addr_space_e;

    // Channel 0 offsets, reg_addr[3:0]
    typedef enum logic [3:0] {
        REG_STATUS = 4'h0,  // Power, relay, watchdog, board ID
        REG_DIGIN  = 4'h1,  // Not kept in this core
        REG_DOUT   = 4'h6   // Digital outputs
    } board_reg_e;

    // Channel 1..8 offsets, reg_addr[3:0]
    typedef enum logic [3:0] {
        OFF_ADC_DATA     = 4'h0,  // Reads zero here
        OFF_DAC_CTRL     = 4'h1,  // Commanded current and amp enable
        OFF_MOTOR_STATUS = 4'h2
    } chan_reg_e;

    // --------------------------------------------------
    // DAC serial frames
    // --------------------------------------------------

    typedef enum logic [1:0] {
        DAC_IDLE,   // Waiting for a request
        DAC_SHIFT,  // csn low, bits going out
        DAC_GAP     // csn high between frames
    } dac_state_e;

    localparam logic [3:0] DAC_CMD_WRITE_UPDATE = 4'd3;  // Write and update DAC
    localparam int         DAC_FRAME_BITS       = 24;    // cmd, 4 pad bits, 16 data
    localparam int         CUR_CMD_W            = 16;

    // DAC_CTRL write fields
    localparam int AMP_EN_MASK_BIT = 29;
    localparam int AMP_EN_VAL_BIT  = 28;

    // STATUS write fields
    localparam int PWR_MASK_BIT   = 19;
    localparam int PWR_VAL_BIT    = 18;
    localparam int RELAY_MASK_BIT = 17;
    localparam int RELAY_VAL_BIT  = 16;

    // STATUS read fields
    localparam int BOARD_ID_LSB   = 24;  // 4 bits wide
    localparam int WDOG_BIT       = 23;
    localparam int PWR_STAT_BIT   = 19;
    localparam int RELAY_STAT_BIT = 17;

endpackage

/* dqla_top.sv */
module dqla_top
    import dqla_pkg::*;
#(
    parameter int NUM_MOTORS     = 8,
    parameter int DACS_PER_CHAIN = NUM_MOTORS / 2
) (
    input  logic                sysclk,
    input  logic                arst_n,
    // Register bus
    input  logic [15:0]         reg_raddr,
    input  logic [15:0]         reg_waddr,
    input  logic [31:0]         reg_wdata,
    input  logic                reg_wen,
    input  logic                blk_wen,
    output logic [31:0]         reg_rdata,
    // Board
    input  logic [3:0]          board_id,      // Rotary switch
    input  logic                wdog_timeout,  // Level from host watchdog
    output logic                wdog_clear,
    output logic                pwr_en,
    output logic                relay_on,
    output logic [7:0]          dout,
    output logic [1:NUM_MOTORS] amp_disable,
    // DAC chains
    output logic                dac_sclk,
    output logic [1:0]          dac_mosi,
    output logic [1:0]          dac_csn
);

    logic [31:0]          board_rdata;
    logic                 pwr_enable_cmd;
    logic [1:NUM_MOTORS]  amp_enable_cmd;
    logic [CUR_CMD_W-1:0] cur_cmd [1:NUM_MOTORS];
    logic [31:0]          motor_status [1:NUM_MOTORS];

    addr_space_e rd_space;
    logic [3:0]  rd_chan;
    chan_reg_e   rd_off;

    // --------------------------------------------------
    // Board register (channel 0)
    // --------------------------------------------------
    board_regs board0 (
        .sysclk         (sysclk),
        .arst_n         (arst_n),
        .reg_waddr      (reg_waddr),
        .reg_wdata      (reg_wdata),
        .reg_wen        (reg_wen),
        .reg_raddr      (reg_raddr),
        .board_id       (board_id),
        .wdog_timeout   (wdog_timeout),
        .pwr_en         (pwr_en),
        .relay_on       (relay_on),
        .dout           (dout),
        .pwr_enable_cmd (pwr_enable_cmd),
        .board_rdata    (board_rdata)
    );

    // --------------------------------------------------
    // Motor channels 1..8
    // --------------------------------------------------
    motor_chan_regs #(.NUM_MOTORS(NUM_MOTORS)) motor0 (
        .sysclk         (sysclk),
        .arst_n         (arst_n),
        .reg_waddr      (reg_waddr),
        .reg_wdata      (reg_wdata),
        .reg_wen        (reg_wen),
        .pwr_en         (pwr_en),
        .wdog_timeout   (wdog_timeout),
        .cur_cmd        (cur_cmd),
        .amp_enable_cmd (amp_enable_cmd),
        .amp_disable    (amp_disable),
        .motor_status   (motor_status)
    );

    // Both chains share sclk, one csn and mosi each
    dac_spi_chain #(.DACS_PER_CHAIN(DACS_PER_CHAIN)) dac0 (
        .sysclk    (sysclk),
        .arst_n    (arst_n),
        .reg_waddr (reg_waddr),
        .reg_wen   (reg_wen),
        .blk_wen   (blk_wen),
        .cur_cmd   (cur_cmd),
        .sclk      (dac_sclk),
        .mosi      (dac_mosi),
        .csn       (dac_csn)
    );

    // Host enabling power or any amp clears the watchdog flag
    assign wdog_clear = pwr_enable_cmd || (amp_enable_cmd != '0);

    // --------------------------------------------------
    // Read mux, zero latency
    // --------------------------------------------------
    assign rd_space = addr_space_e'(reg_raddr[15:12]);
    assign rd_chan  = reg_raddr[7:4];
    assign rd_off   = chan_reg_e'(reg_raddr[3:0]);

    always_comb begin
        reg_rdata = '0;  // Unused spaces, channels, offsets
        if (rd_space == ADDR_MAIN) begin
            if (rd_chan == 4'd0) begin
                reg_rdata = board_rdata;
            end else if (rd_chan <= 4'(NUM_MOTORS)) begin
                case (rd_off)
                    OFF_DAC_CTRL:     reg_rdata = {16'd0, cur_cmd[rd_chan]};
                    OFF_MOTOR_STATUS: reg_rdata = motor_status[rd_chan];
                    default:          reg_rdata = '0;
                endcase
            end
        end
    end

endmodule

/* motor_chan_regs.sv */
module motor_chan_regs
    import dqla_pkg::*;
#(
    parameter int NUM_MOTORS = 8
) (
    input  logic                 sysclk,
    input  logic                 arst_n,
    input  logic [15:0]          reg_waddr,
    input  logic [31:0]          reg_wdata,
    input  logic                 reg_wen,
    input  logic                 pwr_en,        // From board register
    input  logic                 wdog_timeout,
    output logic [CUR_CMD_W-1:0] cur_cmd [1:NUM_MOTORS],
    output logic [1:NUM_MOTORS]  amp_enable_cmd,  // Host enable attempt
    output logic [1:NUM_MOTORS]  amp_disable,     // Active high to amp
    output logic [31:0]          motor_status [1:NUM_MOTORS]
);

    logic                wr_main;
    logic [3:0]          wr_chan;
    chan_reg_e           wr_off;
    logic [1:NUM_MOTORS] amp_en_reg;  // Host requested enable
    logic [1:NUM_MOTORS] amp_on;      // Actually driving

    // Shared write decode
    assign wr_main = reg_wen && (addr_space_e'(reg_waddr[15:12]) == ADDR_MAIN);
    assign wr_chan = reg_waddr[7:4];
    assign wr_off  = chan_reg_e'(reg_waddr[3:0]);

    // --------------------------------------------------
    // One slice per channel
    // --------------------------------------------------
    for (genvar k = 1; k <= NUM_MOTORS; k++) begin : g_chan
        logic dac_wr;
        logic en_mask;
        logic en_val;

        assign dac_wr  = wr_main && (wr_chan == 4'(k)) && (wr_off == OFF_DAC_CTRL);
        assign en_mask = reg_wdata[AMP_EN_MASK_BIT];
        assign en_val  = reg_wdata[AMP_EN_VAL_BIT];

        // Seen on the write cycle itself
        assign amp_enable_cmd[k] = dac_wr && en_mask && en_val;

        always_ff @(posedge sysclk or negedge arst_n) begin
            if (!arst_n) begin
                cur_cmd[k]    <= '0;
                amp_en_reg[k] <= 1'b0;
            end else begin
                if (dac_wr) begin
                    cur_cmd[k] <= reg_wdata[CUR_CMD_W-1:0];
                end
                // Watchdog wins over a simultaneous enable
                if (wdog_timeout) begin
                    amp_en_reg[k] <= 1'b0;
                end else if (dac_wr && en_mask) begin
                    amp_en_reg[k] <= en_val;
                end
            end
        end

        // Needs board power as well
        assign amp_on[k]      = amp_en_reg[k] && pwr_en;
        assign amp_disable[k] = !amp_on[k];

        // Bit 2 wdog, bit 1 enable reg, bit 0 amp on
        assign motor_status[k] = {29'd0, wdog_timeout, amp_en_reg[k], amp_on[k]};
    end

endmodule

/* project.f */
dqla_pkg.sv
board_regs.sv
motor_chan_regs.sv
dac_spi_chain.sv
dqla_top.sv
tb_dqla.sv

/* tb_dqla.sv */
module tb_dqla
    import dqla_pkg::*;
();

    localparam int MAX_CYCLES = 5000;  // Tests need about 1500

    logic        sysclk;
    logic        arst_n;
    logic [15:0] reg_raddr;
    logic [15:0] reg_waddr;
    logic [31:0] reg_wdata;
    logic        reg_wen;
    logic        blk_wen;
    logic [3:0]  board_id;
    logic        wdog_timeout;
    logic [31:0] reg_rdata;
    logic        wdog_clear;
    logic        pwr_en;
    logic        relay_on;
    logic [7:0]  dout;
    logic [1:8]  amp_disable;
    logic        dac_sclk;
    logic [1:0]  dac_mosi;
    logic [1:0]  dac_csn;

    int          err_cnt;
    int          check_cnt;
    int          test_cnt;
    int          cycle_cnt;
    logic        clr_seen;        // wdog_clear during the last write
    logic        exp_pwr;
    logic        exp_relay;
    logic [15:0] exp_cur [1:8];   // Model of commanded currents
    logic [15:0] xfer_cur [1:8];  // What the next transfer should carry
    logic [23:0] mon_sr [2];
    int          mon_bits [2];
    logic [23:0] frames0 [$];     // Chain 0, channels 1..4
    logic [23:0] frames1 [$];     // Chain 1, channels 5..8

    dqla_top dut0 (.*);

    initial begin
        sysclk = 1'b0;
        forever #2 sysclk = !sysclk;
    end

    // --------------------------------------------------
    // DAC monitor, 24 rising sclk edges per frame
    // --------------------------------------------------
    always @(posedge dac_sclk) begin
        for (int c = 0; c < 2; c++) begin
            if (!dac_csn[c]) begin
                mon_sr[c]   = {mon_sr[c][22:0], dac_mosi[c]};  // MSB first
                mon_bits[c] = mon_bits[c] + 1;
                if (mon_bits[c] == 24) begin
                    if (c == 0) begin
                        frames0.push_back(mon_sr[c]);
                    end else begin
                        frames1.push_back(mon_sr[c]);
                    end
                    mon_bits[c] = 0;
                end
            end
        end
    end

    // Run limit
    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < MAX_CYCLES) begin
            @(posedge sysclk);
            cycle_cnt++;
        end
        $display("Timeout: tests still running after %0d clock cycles", MAX_CYCLES);
        $display("SIMULATION FAILED");
        $finish;
    end

    // --------------------------------------------------
    // Bus and check helpers
    // --------------------------------------------------
    task automatic step();
        @(posedge sysclk);
        #1;  // Drive point
    endtask

    task automatic check_eq(input logic [31:0] got, input logic [31:0] want, input string msg);
        check_cnt++;
        if (got !== want) begin
            err_cnt++;
            $display("Mismatch at time %0t: %s, got %h, expected %h", $time, msg, got, want);
        end
    endtask

    function automatic logic [15:0] make_addr(input logic [3:0] space, input logic [3:0] chan,
                                              input logic [3:0] off);
        return {space, 4'h0, chan, off};
    endfunction

    // STATUS layout from the board register map
    function automatic logic [31:0] status_word(input logic wdog);
        return (32'(board_id) << BOARD_ID_LSB) | (32'(wdog) << WDOG_BIT)
             | (32'(exp_pwr) << PWR_STAT_BIT) | (32'(exp_relay) << RELAY_STAT_BIT);
    endfunction

    task automatic write_reg(input logic [15:0] addr, input logic [31:0] data, input logic blk);
        reg_waddr = addr;
        reg_wdata = data;
        reg_wen   = 1'b1;
        blk_wen   = blk;
        @(negedge sysclk);
        clr_seen = wdog_clear;  // Mid-cycle, before the write edge
        step();
        reg_wen = 1'b0;
        blk_wen = 1'b0;
    endtask

    task automatic read_check(input logic [15:0] addr, input logic [31:0] want, input string msg);
        reg_raddr = addr;
        @(negedge sysclk);
        check_eq(reg_rdata, want, msg);
        step();
    endtask

    // Power and relay fields, each under its mask
    task automatic set_status(input logic pm, input logic pv, input logic rm, input logic rv);
        logic [31:0] data;
        data = (32'(pm) << PWR_MASK_BIT) | (32'(pv) << PWR_VAL_BIT)
             | (32'(rm) << RELAY_MASK_BIT) | (32'(rv) << RELAY_VAL_BIT);
        write_reg(make_addr(ADDR_MAIN, 4'h0, REG_STATUS), data, 1'b0);
        if (pm) exp_pwr = pv;
        if (rm) exp_relay = rv;
    endtask

    task automatic write_cur(input int k, input logic [15:0] val, input logic blk);
        exp_cur[k] = val;
        write_reg(make_addr(ADDR_MAIN, 4'(k), OFF_DAC_CTRL), {16'd0, val}, blk);
    endtask

    task automatic snap_currents();
        for (int k = 1; k <= 8; k++) xfer_cur[k] = exp_cur[k];
    endtask

    // Start on csn low, done when all frames are in and csn is high again
    task automatic wait_transfer(input int nframes);
        int n;
        n = 0;
        while (dac_csn == 2'b11 && n < 10) begin
            step();
            n++;
        end
        if (dac_csn == 2'b11) begin
            err_cnt++;
            $display("Error at time %0t: DAC transfer did not start", $time);
        end else begin
            n = 0;
            while (!(frames0.size() >= nframes && frames1.size() >= nframes && dac_csn == 2'b11)
                   && n <= 200) begin
                step();
                n++;
            end
            if (n > 200) begin
                err_cnt++;
                $display("Error at time %0t: DAC transfer not done within 200 cycles", $time);
            end
            repeat (2) step();  // Last csn gap
        end
    endtask

    task automatic expect_dac_quiet(input int cycles, input string msg);
        logic quiet;
        quiet = 1'b1;
        repeat (cycles) begin
            step();
            if (dac_csn != 2'b11) quiet = 1'b0;
        end
        if (!quiet) begin
            err_cnt++;
            $display("Error at time %0t: unexpected DAC transfer, %s", $time, msg);
        end
    endtask

    // Command 3, four zero bits, then the current
    task automatic check_frames(input int first);
        for (int i = 0; i < 4; i++) begin
            check_eq(frames0[first + i], {4'd3, 4'd0, xfer_cur[i + 1]},
                     $sformatf("chain 0 frame %0d", first + i));
            check_eq(frames1[first + i], {4'd3, 4'd0, xfer_cur[i + 5]},
                     $sformatf("chain 1 frame %0d", first + i));
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        test_cnt++;
        if (err_cnt == errs_before) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d errors", name, err_cnt - errs_before);
        end
    endtask

    // --------------------------------------------------
    // Tests
    // --------------------------------------------------
    task automatic test_reset_state();
        int e;
        e = err_cnt;
        check_eq(amp_disable, 8'hff, "amp_disable after reset");
        check_eq(dac_csn, 2'b11, "csn after reset");
        check_eq(dac_sclk, 1'b0, "sclk after reset");
        check_eq({pwr_en, relay_on, dout, wdog_clear}, '0, "board outputs after reset");
        for (int ch = 0; ch < 10; ch++) begin
            for (int off = 0; off < 8; off++) begin
                read_check(make_addr(ADDR_MAIN, 4'(ch), 4'(off)),
                           (ch == 0 && off == 0) ? status_word(1'b0) : 32'd0,
                           $sformatf("reset read ch %0d off %0d", ch, off));
            end
        end
        read_check(make_addr(4'h1, 4'h0, REG_STATUS), '0, "other space after reset");
        report_test("reset_state", e);
    endtask

    task automatic test_board_regs();
        int          e;
        logic [31:0] d;
        e = err_cnt;
        set_status(1'b1, 1'b1, 1'b1, 1'b1);
        check_eq(clr_seen, 1'b1, "wdog_clear on power write");
        check_eq({pwr_en, relay_on}, 2'b11, "power and relay on");
        set_status(1'b1, 1'b0, 1'b0, 1'b0);  // Relay field not masked
        check_eq(clr_seen, 1'b0, "wdog_clear on power off");
        check_eq({pwr_en, relay_on}, 2'b01, "relay kept without mask");
        read_check(make_addr(ADDR_MAIN, 4'h0, REG_STATUS), status_word(1'b0), "status read");
        set_status(1'b1, 1'b1, 1'b1, 1'b0);
        check_eq({pwr_en, relay_on}, 2'b10, "power on, relay off");
        set_status(1'b0, 1'b0, 1'b1, 1'b1);  // Power field not masked
        check_eq({pwr_en, relay_on}, 2'b11, "power kept without mask");
        d = $urandom;
        write_reg(make_addr(ADDR_MAIN, 4'h0, REG_DOUT), d, 1'b0);
        check_eq(dout, d[7:0], "dout pins");
        read_check(make_addr(ADDR_MAIN, 4'h0, REG_DOUT), {24'd0, d[7:0]}, "dout read");
        read_check(make_addr(ADDR_MAIN, 4'h0, 4'h3), '0, "unused board offset");
        read_check(make_addr(4'h1, 4'h0, REG_DOUT), '0, "dout in other space");
        read_check(make_addr(ADDR_MAIN, 4'hc, OFF_DAC_CTRL), '0, "channel 12");
        report_test("board_regs", e);
    endtask

    task automatic test_motor_regs();
        int e;
        e = err_cnt;
        for (int k = 1; k <= 8; k++) write_cur(k, 16'($urandom), 1'b0);
        for (int k = 1; k <= 8; k++) begin
            read_check(make_addr(ADDR_MAIN, 4'(k), OFF_DAC_CTRL), {16'd0, exp_cur[k]},
                       $sformatf("cur_cmd ch %0d", k));
            read_check(make_addr(ADDR_MAIN, 4'(k), OFF_MOTOR_STATUS), '0,
                       $sformatf("status ch %0d before enable", k));
        end
        for (int k = 1; k <= 8; k++) begin  // Mask and value set, power on
            write_reg(make_addr(ADDR_MAIN, 4'(k), OFF_DAC_CTRL),
                      32'h3000_0000 | {16'd0, exp_cur[k]}, 1'b0);
            check_eq(clr_seen, 1'b1, $sformatf("wdog_clear on enable ch %0d", k));
            check_eq(amp_disable[k], 1'b0, $sformatf("amp on ch %0d", k));
        end
        read_check(make_addr(ADDR_MAIN, 4'h3, OFF_MOTOR_STATUS), 32'h3, "status ch 3 enabled");
        set_status(1'b1, 1'b0, 1'b0, 1'b0);
        check_eq(amp_disable, 8'hff, "amps off without power");
        read_check(make_addr(ADDR_MAIN, 4'h5, OFF_MOTOR_STATUS), 32'h2, "enable kept, amp off");
        set_status(1'b1, 1'b1, 1'b0, 1'b0);
        check_eq(amp_disable, 8'h00, "amps back on with power");
        report_test("motor_regs", e);
    endtask

    task automatic test_dac_transfer();
        int e;
        e = err_cnt;
        frames0.delete();
        frames1.delete();
        for (int k = 1; k <= 8; k++) write_cur(k, 16'($urandom), k == 8);  // Block on last
        snap_currents();
        wait_transfer(4);
        check_eq(frames0.size(), 4, "chain 0 frame count");
        check_eq(frames1.size(), 4, "chain 1 frame count");
        check_frames(0);
        report_test("dac_transfer", e);
    endtask

    task automatic test_back_pressure();
        int e;
        e = err_cnt;
        frames0.delete();
        frames1.delete();
        write_cur(1, exp_cur[1], 1'b1);
        snap_currents();  // Captured at start
        step();
        write_cur(2, 16'($urandom), 1'b1);  // Both while busy
        write_cur(6, 16'($urandom), 1'b1);
        wait_transfer(4);
        check_frames(0);
        snap_currents();
        wait_transfer(8);
        check_eq(frames0.size(), 8, "chain 0 frames after merge");
        check_eq(frames1.size(), 8, "chain 1 frames after merge");
        check_frames(4);
        expect_dac_quiet(250, "third transfer after merge");
        write_cur(3, 16'($urandom), 1'b0);
        expect_dac_quiet(60, "after non-block write");
        check_eq(frames0.size(), 8, "no frames from non-block write");
        report_test("back_pressure", e);
    endtask

    task automatic test_watchdog();
        int e;
        e = err_cnt;
        wdog_timeout = 1'b1;
        step();
        exp_pwr = 1'b0;
        check_eq(pwr_en, 1'b0, "power cleared by watchdog");
        check_eq(amp_disable, 8'hff, "amps cleared by watchdog");
        read_check(make_addr(ADDR_MAIN, 4'h4, OFF_MOTOR_STATUS), 32'h4, "status with watchdog");
        read_check(make_addr(ADDR_MAIN, 4'h0, REG_STATUS), status_word(1'b1), "status wdog bit");
        set_status(1'b1, 1'b1, 1'b0, 1'b0);  // Loses against the timeout
        exp_pwr = 1'b0;
        check_eq(clr_seen, 1'b1, "wdog_clear on power write in timeout");
        check_eq(pwr_en, 1'b0, "power stays off in timeout");
        wdog_timeout = 1'b0;
        set_status(1'b1, 1'b1, 1'b0, 1'b0);
        check_eq(clr_seen, 1'b1, "wdog_clear on power write");
        check_eq(pwr_en, 1'b1, "power on after timeout");
        check_eq(amp_disable, 8'hff, "enables stay cleared");
        write_reg(make_addr(ADDR_MAIN, 4'h1, OFF_DAC_CTRL), 32'h3000_0000 | {16'd0, exp_cur[1]},
                  1'b0);
        check_eq(clr_seen, 1'b1, "wdog_clear on amp re-enable");
        check_eq(amp_disable, 8'h7f, "ch 1 back on");
        report_test("watchdog", e);
    endtask

    // --------------------------------------------------
    // Main sequence
    // --------------------------------------------------
    initial begin
        void'($urandom(72));
        err_cnt      = 0;
        check_cnt    = 0;
        test_cnt     = 0;
        arst_n       = 1'b0;
        reg_raddr    = '0;
        reg_waddr    = '0;
        reg_wdata    = '0;
        reg_wen      = 1'b0;
        blk_wen      = 1'b0;
        board_id     = 4'ha;
        wdog_timeout = 1'b0;
        exp_pwr      = 1'b0;
        exp_relay    = 1'b0;
        clr_seen     = 1'b0;
        mon_bits     = '{0, 0};
        mon_sr       = '{24'd0, 24'd0};
        for (int k = 1; k <= 8; k++) exp_cur[k] = '0;
        repeat (4) @(posedge sysclk);
        #1;
        arst_n = 1'b1;
        test_reset_state();
        test_board_regs();
        test_motor_regs();
        test_dac_transfer();
        test_back_pressure();
        test_watchdog();
        $display("Tests: %0d, checks: %0d, errors: %0d", test_cnt, check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule
